/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_dz_show
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG   ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* project.f */
rtl/dz_pkg.sv
rtl/dz_row_scan.sv
rtl/dz_col_driver.sv
rtl/dz_show.sv
tb/dz_show_asserts.sv
tb/tb_dz_show.sv

/* rtl/dz_col_driver.sv */
module dz_col_driver (
    input  logic              clk,
    input  logic              rst,
    input  logic              st,
    input  logic              temp,
    input  dz_pkg::glyph_t    num,
    input  dz_pkg::row_idx_t  row_idx,
    output dz_pkg::col_t      colg,
    output dz_pkg::col_t      colr
);

    dz_pkg::glyph_t glyph_q;
    dz_pkg::col_t   pattern;
    logic           glyph_valid;

    // glyph code latch
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            glyph_q <= '0;
        else if (!st)
            glyph_q <= '0;
        else
            glyph_q <= num;
    end

    // codes 12..15 show nothing
    assign glyph_valid = (glyph_q < dz_pkg::glyph_t'(dz_pkg::NUM_GLYPHS));

    always_comb
    begin
        if (glyph_valid)
            pattern = dz_pkg::glyph_row(glyph_q, row_idx);
        else
            pattern = '0;
    end

    // columns register on the same edge as the row select
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            colg <= '0;
            colr <= '0;
        end
        else if (!st)
        begin
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            colg <= pattern;
            colr <= temp ? pattern : '0; // red + green gives yellow
        end
    end

endmodule

/* rtl/dz_pkg.sv */
package dz_pkg;

    typedef logic [3:0] glyph_t;   // code on num
    typedef logic [2:0] row_idx_t;
    typedef logic [7:0] col_t;     // 1 = lit dot, also the row bus

    localparam int NUM_GLYPHS = 12;

    // bitmap row for one glyph
    function automatic col_t glyph_row(glyph_t code, row_idx_t r);
        col_t bits;
        bits = '0;
        case (code)
            4'd0:
                case (r)
                    3'd2, 3'd5: bits = 8'b0001_1000;
                    3'd3, 3'd4: bits = 8'b0011_1100;
                    default: bits = '0;
                endcase
            4'd1:
                case (r)
                    3'd2, 3'd5: bits = 8'b0011_1000;
                    3'd3, 3'd4: bits = 8'b0111_1100;
                    default: bits = '0;
                endcase
            4'd2:
                case (r)
                    3'd2, 3'd5: bits = 8'b0011_1100;
                    3'd3, 3'd4: bits = 8'b0111_1110;
                    default: bits = '0;
                endcase
            4'd3:
                case (r)
                    3'd1, 3'd6: bits = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: bits = 8'b0111_1110;
                    default: bits = '0;
                endcase
            4'd4:
                case (r)
                    3'd0, 3'd7: bits = 8'b0011_1100;
                    3'd1, 3'd6: bits = 8'b0111_1110;
                    default: bits = 8'b1111_1111; // rows 2 to 5
                endcase
            4'd5:
                bits = 8'b1111_1111; // full block
            4'd6:
                case (r)
                    3'd0: bits = 8'b1100_0011;
                    3'd1: bits = 8'b1110_0011;
                    3'd2: bits = 8'b1111_0001;
                    3'd3: bits = 8'b1110_0011;
                    3'd4: bits = 8'b1100_0111;
                    3'd5: bits = 8'b1110_0111;
                    3'd6: bits = 8'b1111_0111;
                    default: bits = 8'b1111_1011;
                endcase
            4'd7:
                case (r)
                    3'd1: bits = 8'b0000_0001;
                    3'd2: bits = 8'b1000_0001;
                    3'd3: bits = 8'b1100_0011;
                    3'd4: bits = 8'b1000_0011;
                    3'd5: bits = 8'b1100_0111;
                    3'd6: bits = 8'b1110_0111;
                    3'd7: bits = 8'b1111_0011;
                    default: bits = '0;
                endcase
            4'd8:
                case (r)
                    3'd1: bits = 8'b0011_1000;
                    3'd2: bits = 8'b0100_0100;
                    3'd3: bits = 8'b0101_1010;
                    3'd4: bits = 8'b0100_1010;
                    3'd5: bits = 8'b0011_0010;
                    3'd6: bits = 8'b1100_0100;
                    3'd7: bits = 8'b0011_1000;
                    default: bits = '0;
                endcase
            4'd9:
                case (r)
                    3'd2: bits = 8'b0110_0000;
                    3'd3: bits = 8'b1111_1100;
                    3'd4: bits = 8'b0011_1111;
                    3'd5: bits = 8'b0011_1110;
                    3'd6: bits = 8'b0001_1100;
                    default: bits = '0;
                endcase
            4'd10:
                case (r)
                    3'd2: bits = 8'b0001_1000;
                    3'd3: bits = 8'b0011_1100;
                    3'd4, 3'd5: bits = 8'b0111_1110;
                    3'd6: bits = 8'b0010_0100;
                    default: bits = '0;
                endcase
            4'd11:
                case (r)
                    3'd0: bits = 8'b1110_0000;
                    3'd1: bits = 8'b0110_0000;
                    3'd2: bits = 8'b1110_0000;
                    3'd3: bits = 8'b0011_0000;
                    3'd4: bits = 8'b0011_0001;
                    3'd5: bits = 8'b0011_0011;
                    3'd6: bits = 8'b0011_1110;
                    default: bits = 8'b0001_1100;
                endcase
            default:
                bits = '0;
        endcase
        return bits;
    endfunction

endpackage

/* rtl/dz_row_scan.sv */
module dz_row_scan #(
    parameter int ROW_HOLD = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              st,
    output dz_pkg::row_idx_t  row_idx,
    output dz_pkg::col_t      row
);

    localparam int HOLD_W = (ROW_HOLD > 1) ? $clog2(ROW_HOLD) : 1;

    logic [HOLD_W-1:0] hold_cnt;
    logic              hold_wrap;

    assign hold_wrap = (hold_cnt == HOLD_W'(ROW_HOLD - 1));

    // hold counter and row index, both parked at zero while st is low
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hold_cnt <= '0;
            row_idx  <= '0;
        end
        else if (!st)
        begin
            hold_cnt <= '0;
            row_idx  <= '0;
        end
        else if (hold_wrap)
        begin
            hold_cnt <= '0;
            row_idx  <= row_idx + 3'd1; // wraps 7 -> 0
        end
        else
        begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    // one low bit per row
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row <= '1;
        else if (!st)
            row <= '1; // all rows off
        else
            row <= ~(dz_pkg::col_t'(1) << row_idx);
    end

endmodule

/* rtl/dz_show.sv */
module dz_show #(
    parameter int ROW_HOLD = 1
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            st,
    input  logic            temp,
    input  dz_pkg::glyph_t  num,
    output dz_pkg::col_t    row,
    output dz_pkg::col_t    colr,
    output dz_pkg::col_t    colg
);

    dz_pkg::row_idx_t row_idx;

    dz_row_scan #(
        .ROW_HOLD (ROW_HOLD)
    ) u_row_scan (
        .clk     (clk),
        .rst     (rst),
        .st      (st),
        .row_idx (row_idx),
        .row     (row)
    );

    // pattern for the row being scanned
    dz_col_driver u_col_driver (
        .clk     (clk),
        .rst     (rst),
        .st      (st),
        .temp    (temp),
        .num     (num),
        .row_idx (row_idx),
        .colg    (colg),
        .colr    (colr)
    );

endmodule

/* tb/dz_show_asserts.sv */
module dz_show_asserts (
    input logic         clk,
    input logic         rst,
    input logic         st,
    input dz_pkg::col_t row,
    input dz_pkg::col_t colg,
    input dz_pkg::col_t colr
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0; // read by the testbench at the end

    // all rows off, or exactly one row pulled low
    a_row_shape: assert property (@(posedge clk) disable iff (rst)
        (row == 8'hFF) || $onehot(~row))
    else
    begin
        $error("row select has more than one active line");
        fail_cnt++;
    end

    a_blank: assert property (@(posedge clk) disable iff (rst)
        !st |=> (row == 8'hFF && colg == 8'h00 && colr == 8'h00))
    else
    begin
        $error("display not blank one clock after st low");
        fail_cnt++;
    end

    // red only ever mirrors green
    a_red_follows: assert property (@(posedge clk) disable iff (rst)
        (colr == 8'h00) || (colr == colg))
    else
    begin
        $error("red columns differ from green columns");
        fail_cnt++;
    end

endmodule

/* tb/tb_dz_show.sv */
module tb_dz_show;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HOLD       = 2;
    localparam int WAIT_LIMIT = 64;
    localparam int EXTRA      = 4;

    logic             clk;
    logic             rst;
    logic             st;
    logic             temp;
    dz_pkg::glyph_t   num;
    dz_pkg::col_t     row;
    dz_pkg::col_t     colr;
    dz_pkg::col_t     colg;

    // stimulus table, one entry per index
    dz_pkg::glyph_t   t_num[$];
    logic             t_temp[$];
    logic             t_st[$];
    dz_pkg::row_idx_t t_row[$];
    dz_pkg::col_t     t_colg[$];

    logic [7:0]       lfsr;

    dz_show #(
        .ROW_HOLD (HOLD)
    ) DUT (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .temp (temp),
        .num  (num),
        .row  (row),
        .colr (colr),
        .colg (colg)
    );

    bind dz_show dz_show_asserts u_asserts (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic dz_pkg::col_t row_pattern(dz_pkg::row_idx_t r);
        dz_pkg::col_t p;
        p = 8'hFF;
        p[r] = 1'b0; // active low
        return p;
    endfunction

    task automatic add_entry(dz_pkg::glyph_t n, logic t, logic s, dz_pkg::row_idx_t r,
                             dz_pkg::col_t g);
        t_num.push_back(n);
        t_temp.push_back(t);
        t_st.push_back(s);
        t_row.push_back(r);
        t_colg.push_back(g);
    endtask

    task automatic fail_stop(string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_outputs(int idx, dz_pkg::col_t exp_row, dz_pkg::col_t exp_g,
                                 dz_pkg::col_t exp_r);
        assert (row === exp_row && colg === exp_g && colr === exp_r)
        else fail_stop($sformatf(
            "mismatch at %0t: entry %0d row exp %h got %h, colg exp %h got %h, colr exp %h got %h",
            $time, idx, exp_row, row, exp_g, colg, exp_r, colr));
    endtask

    // polls on the falling edge, registered outputs are stable there
    task automatic wait_row(dz_pkg::row_idx_t r, output logic found);
        int n;
        found = 1'b0;
        n = 0;
        while (!found && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            found = (row == row_pattern(r));
            n++;
        end
    endtask

    task automatic apply_entry(int idx, dz_pkg::glyph_t n, logic t, logic s,
                               dz_pkg::row_idx_t r, dz_pkg::col_t g);
        logic found;
        @(posedge clk);
        #1;
        num  = n;
        temp = t;
        st   = s;
        repeat (HOLD) @(posedge clk); // glyph latch then column register
        wait_row(r, found);
        if (s)
        begin
            if (!found)
                fail_stop($sformatf("row %0d was never reached for entry %0d", r, idx));
            else
                check_outputs(idx, row_pattern(r), g, t ? g : 8'h00);
        end
        else
        begin
            if (found)
                fail_stop($sformatf("row %0d was driven while st was low, entry %0d", r, idx));
            else
                check_outputs(idx, 8'hFF, 8'h00, 8'h00);
        end
    endtask

    // drop st, raise it, then follow one full scan plus the wrap
    task automatic check_scan();
        int   n;
        int   exp_idx;
        logic seen;
        @(posedge clk);
        #1;
        st = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_outputs(-1, 8'hFF, 8'h00, 8'h00);
        @(posedge clk);
        #1;
        st = 1'b1;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            seen = (row != 8'hFF);
            n++;
        end
        if (!seen)
            fail_stop("no row was driven after st went high");
        else
        begin
            assert (row === row_pattern(3'd0))
            else fail_stop($sformatf("mismatch at %0t: scan restarted with row %h, not row 0",
                                     $time, row));
            for (int k = 1; k <= 16; k++)
            begin
                @(negedge clk);
                exp_idx = (k / HOLD) % 8;
                assert (row === row_pattern(exp_idx[2:0]))
                else fail_stop($sformatf(
                    "mismatch at %0t: scan step %0d row exp %h got %h",
                    $time, k, row_pattern(exp_idx[2:0]), row));
            end
        end
    endtask

    initial
    begin
        rst  = 1'b1;
        st   = 1'b0;
        temp = 1'b0;
        num  = '0;
        lfsr = 8'd3;

        add_entry(4'd0, 1'b1, 1'b1, 3'd0, 8'h00);
        add_entry(4'd0, 1'b0, 1'b1, 3'd3, 8'h3C);
        add_entry(4'd1, 1'b1, 1'b1, 3'd1, 8'h00);
        add_entry(4'd1, 1'b1, 1'b1, 3'd4, 8'h7C);
        add_entry(4'd2, 1'b0, 1'b1, 3'd7, 8'h00);
        add_entry(4'd2, 1'b1, 1'b1, 3'd2, 8'h3C);
        add_entry(4'd3, 1'b1, 1'b1, 3'd0, 8'h00);
        add_entry(4'd3, 1'b0, 1'b1, 3'd6, 8'h3C);
        add_entry(4'd4, 1'b1, 1'b1, 3'd0, 8'h3C);
        add_entry(4'd4, 1'b0, 1'b1, 3'd3, 8'hFF);
        add_entry(4'd5, 1'b1, 1'b1, 3'd1, 8'hFF);
        add_entry(4'd5, 1'b0, 1'b1, 3'd6, 8'hFF);
        add_entry(4'd6, 1'b1, 1'b1, 3'd2, 8'hF1);
        add_entry(4'd6, 1'b0, 1'b1, 3'd2, 8'hF1); // same spot, red off
        add_entry(4'd6, 1'b1, 1'b1, 3'd7, 8'hFB);
        add_entry(4'd7, 1'b0, 1'b1, 3'd0, 8'h00);
        add_entry(4'd7, 1'b1, 1'b1, 3'd5, 8'hC7);
        add_entry(4'd8, 1'b1, 1'b1, 3'd0, 8'h00);
        add_entry(4'd8, 1'b1, 1'b1, 3'd6, 8'hC4);
        add_entry(4'd8, 1'b0, 1'b1, 3'd6, 8'hC4);
        add_entry(4'd9, 1'b0, 1'b1, 3'd7, 8'h00);
        add_entry(4'd9, 1'b1, 1'b1, 3'd3, 8'hFC);
        add_entry(4'd10, 1'b1, 1'b1, 3'd1, 8'h00);
        add_entry(4'd10, 1'b0, 1'b1, 3'd6, 8'h24);
        add_entry(4'd11, 1'b1, 1'b1, 3'd0, 8'hE0);
        add_entry(4'd11, 1'b0, 1'b1, 3'd5, 8'h33);
        add_entry(4'd12, 1'b1, 1'b1, 3'd3, 8'h00); // blank codes
        add_entry(4'd13, 1'b0, 1'b1, 3'd4, 8'h00);
        add_entry(4'd14, 1'b1, 1'b1, 3'd5, 8'h00);
        add_entry(4'd15, 1'b1, 1'b1, 3'd0, 8'h00);
        add_entry(4'd5, 1'b1, 1'b0, 3'd2, 8'h00);  // st low, row never shows
        add_entry(4'd5, 1'b1, 1'b1, 3'd0, 8'hFF);

        repeat (8) @(posedge clk);
        @(negedge clk);
        check_outputs(-1, 8'hFF, 8'h00, 8'h00); // idle in reset
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        check_scan();

        for (int i = 0; i < t_num.size(); i++)
            apply_entry(i, t_num[i], t_temp[i], t_st[i], t_row[i], t_colg[i]);

        // replay some entries with a pseudo random temp
        for (int i = 0; i < EXTRA; i++)
        begin
            apply_entry(t_num.size() + i, t_num[2 * i + 1], lfsr[7], 1'b1,
                        t_row[2 * i + 1], t_colg[2 * i + 1]);
            lfsr = lfsr_step(lfsr);
        end

        check_scan();
        repeat (4) @(posedge clk);

        if (DUT.u_asserts.fail_cnt == 0)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
            fail_stop($sformatf("%0d bound assertion failures", DUT.u_asserts.fail_cnt));
    end

endmodule
